/* src/burstBufferPkg.sv */
//------------------------------
// Burst buffer shared definitions
// Payload and count types, buffer depth, burst length
// and controller state encoding
//------------------------------
package burstBufferPkg;

  //------------------------------
  // Payload
  //------------------------------
  typedef logic [7:0] payloadType;                       // One stored byte

  //------------------------------
  // Buffer geometry
  //------------------------------
  localparam int BufferDepth  = 16;                      // Usable entries
  localparam int CountWidth   = $clog2(BufferDepth) + 1; // Holds 0 .. BufferDepth
  localparam int PointerWidth = $clog2(BufferDepth);     // Index into storage

  typedef logic [CountWidth-1:0]   countType;            // Remainder counts
  typedef logic [PointerWidth-1:0] pointerType;          // Head and tail pointers

  //------------------------------
  // Burst shaping
  //------------------------------
  localparam int BurstLength = 4;                        // Words per full burst

  // Drain controller states
  typedef enum logic [1:0] {
    stateIdle  = 2'd0,                                   // Waiting for data or flush
    stateBurst = 2'd1,                                   // Reading a full burst
    stateFlush = 2'd2                                    // Draining a partial amount
  } drainStateType;

endpackage

/* src/bufferPort.sv */
//------------------------------
// Read side of the circular buffer
// Modports for the buffer and the drain controller
//------------------------------
`timescale 1ns/1ps

interface bufferPort import burstBufferPkg::*; ();

  logic       readEnable;                                // Pop one element this cycle
  payloadType readData;                                  // Popped element, one cycle late
  logic       readValid;                                 // Strobe for readData
  countType   outRemainder;                              // Elements stored
  countType   inRemainder;                               // Free entries

  // Storage side
  modport buffer (
    input  readEnable,
    output readData,
    output readValid,
    output outRemainder,
    output inRemainder
  );

  // Drain controller side needs only the fill level
  modport controller (
    output readEnable,
    input  outRemainder
  );

endinterface

/* src/circularBuffer.sv */
//------------------------------
// Circular byte buffer
// Storage array, head and tail pointers, occupancy,
// registered read data and overflow pulse
//------------------------------
`timescale 1ns/1ps

module circularBuffer import burstBufferPkg::*; (
  input  logic       clock,
  input  logic       reset,
  input  logic       inEnable,                           // Store in at this edge
  input  payloadType in,                                 // Byte to store
  output logic       overflow,                           // Write dropped last edge
  bufferPort.buffer  port                                // Read side
);

  //------------------------------
  // State
  //------------------------------
  payloadType storage [BufferDepth];                     // Element array
  pointerType headPointer;                               // Next element to read
  pointerType tailPointer;                               // Next slot to write
  countType   occupancy;                                 // Elements stored

  logic isFull;                                          // No free slot
  logic doWrite;                                         // Accepted write
  logic doRead;                                          // Pop this edge

  // Pointer advance with explicit wrap at BufferDepth
  function automatic pointerType nextPointer(input pointerType pointer);
    pointerType result;
    if (pointer == pointerType'(BufferDepth - 1)) begin
      result = '0;                                       // Wrap to start
    end else begin
      result = pointer + 1'b1;
    end
    return result;
  endfunction

  assign isFull  = (occupancy == countType'(BufferDepth));
  assign doWrite = inEnable && !isFull;                  // Full write is dropped
  assign doRead  = port.readEnable;                      // Controller guarantees data

  //------------------------------
  // Storage and read data
  //------------------------------
  always_ff @(posedge clock) begin
    if (doWrite) begin
      storage[tailPointer] <= in;                        // Store at the tail
    end
    if (doRead) begin
      port.readData <= storage[headPointer];             // Head appears next cycle
    end
  end

  //------------------------------
  // Pointers and occupancy
  //------------------------------
  always_ff @(posedge clock) begin
    if (reset) begin
      headPointer <= '0;
      tailPointer <= '0;
      occupancy   <= '0;                                 // Empty
    end else begin
      if (doWrite) begin
        tailPointer <= nextPointer(tailPointer);
      end
      if (doRead) begin
        headPointer <= nextPointer(headPointer);
      end
      case ({doWrite, doRead})
        2'b10:   occupancy <= occupancy + 1'b1;          // Write only
        2'b01:   occupancy <= occupancy - 1'b1;          // Read only
        default: occupancy <= occupancy;                 // Both or neither
      endcase
    end
  end

  // Strobes
  always_ff @(posedge clock) begin
    if (reset) begin
      port.readValid <= 1'b0;
      overflow       <= 1'b0;
    end else begin
      port.readValid <= doRead;                          // One cycle read latency
      overflow       <= inEnable && isFull;              // Pulse per dropped byte
    end
  end

  // Remainders always sum to BufferDepth
  assign port.outRemainder = occupancy;
  assign port.inRemainder  = countType'(BufferDepth) - occupancy;

  //------------------------------
  // Checks
  //------------------------------
  // Controller must never pop an empty buffer
  readWhenEmpty: assert property (
    @(posedge clock) disable iff (reset)
      port.readEnable |-> (port.outRemainder != '0)
  ) else $error("read requested with buffer empty");

  // Occupancy stays within the array
  occupancyBound: assert property (
    @(posedge clock) disable iff (reset)
      occupancy <= countType'(BufferDepth)
  ) else $error("occupancy above BufferDepth");

endmodule

/* src/burstCounter.sv */
//------------------------------
// Loadable down-counter
// Words left in the current read run
//------------------------------
`timescale 1ns/1ps

module burstCounter import burstBufferPkg::*; (
  input  logic     clock,
  input  logic     reset,
  input  logic     load,                                 // Start a new run
  input  countType loadValue,                            // Words in the run
  input  logic     step,                                 // One word read
  output logic     last                                  // Exactly one word left
);

  countType count;                                       // Words still to read

  always_ff @(posedge clock) begin
    if (reset) begin
      count <= '0;
    end else if (load) begin
      count <= loadValue;                                // New run takes priority
    end else if (step) begin
      count <= count - 1'b1;
    end
  end

  assign last = (count == countType'(1));               // Combinational on count

  //------------------------------
  // Checks
  //------------------------------
  // A step past the end of a run would wrap the count
  stepUnderflow: assert property (
    @(posedge clock) disable iff (reset)
      (step && !load) |-> (count != '0)
  ) else $error("step with no words left");

endmodule

/* src/drainControl.sv */
//------------------------------
// Drain controller FSM
// Starts bursts and flushes, drives read enable,
// counter load and step
//------------------------------
`timescale 1ns/1ps

module drainControl import burstBufferPkg::*; (
  input  logic          clock,
  input  logic          reset,
  input  logic          flush,                           // Drain a partial amount
  bufferPort.controller port,                            // Read enable and fill level
  output logic          load,                            // Counter load pulse
  output countType      loadValue,                       // Words for this run
  output logic          step,                            // Counter step pulse
  input  logic          last,                            // Final word of the run
  output logic          burstActive                      // Full burst in progress
);

  //------------------------------
  // Start conditions
  //------------------------------
  drainStateType state;                                  // Current FSM state

  logic isIdle;
  logic startBurst;                                      // Enough data for a burst
  logic startFlush;                                      // Partial data and flush asked
  logic hasData;

  assign isIdle     = (state == stateIdle);
  assign hasData    = (port.outRemainder != '0);
  assign startBurst = isIdle && (port.outRemainder >= countType'(BurstLength));
  assign startFlush = isIdle && flush && hasData &&
                      (port.outRemainder < countType'(BurstLength));

  // Counter control
  assign load      = startBurst || startFlush;           // Pulse on the start edge
  assign loadValue = startBurst ? countType'(BurstLength)
                                : port.outRemainder;     // Flush takes what is stored
  assign step      = port.readEnable;                    // Every read counts one word

  //------------------------------
  // State machine
  //------------------------------
  always_ff @(posedge clock) begin
    if (reset) begin
      state           <= stateIdle;
      port.readEnable <= 1'b0;
      burstActive     <= 1'b0;
    end else begin
      case (state)
        stateIdle: begin
          if (startBurst) begin                          // Burst wins over flush
            state           <= stateBurst;
            port.readEnable <= 1'b1;
            burstActive     <= 1'b1;
          end else if (startFlush) begin
            state           <= stateFlush;
            port.readEnable <= 1'b1;
          end
        end
        stateBurst: begin
          if (last) begin                                // Final read this edge
            state           <= stateIdle;
            port.readEnable <= 1'b0;
            burstActive     <= 1'b0;
          end
        end
        stateFlush: begin
          if (last) begin
            state           <= stateIdle;
            port.readEnable <= 1'b0;
          end
        end
        default: begin                                   // Unused encoding
          state           <= stateIdle;
          port.readEnable <= 1'b0;
          burstActive     <= 1'b0;
        end
      endcase
    end
  end

  //------------------------------
  // Checks
  //------------------------------
  // A full burst holds burstActive for exactly BurstLength cycles
  burstSpan: assert property (
    @(posedge clock) disable iff (reset)
      $fell(burstActive) |-> $past(burstActive, BurstLength) &&
                             !$past(burstActive, BurstLength + 1)
  ) else $error("burstActive length differs from BurstLength");

endmodule

/* src/burstBuffer.sv */
//------------------------------
// Burst buffer top level
// Circular buffer, run counter and drain controller
//------------------------------
`timescale 1ns/1ps

module burstBuffer import burstBufferPkg::*; (
  input  logic       clock,
  input  logic       reset,
  input  logic       inEnable,                           // Write strobe
  input  payloadType in,                                 // Write byte
  input  logic       flush,                              // Drain partial data
  output countType   inRemainder,                        // Free entries
  output countType   outRemainder,                       // Stored entries
  output payloadType out,                                // Read byte
  output logic       outValid,                           // One strobe per byte
  output logic       overflow,                           // Dropped write
  output logic       burstActive                         // Full burst running
);

  //------------------------------
  // Internal wiring
  //------------------------------
  bufferPort readPort ();                                // Buffer to controller

  logic     load;                                        // Counter load
  countType loadValue;                                   // Words in run
  logic     step;                                        // Counter step
  logic     last;                                        // Final word

  circularBuffer u_buffer (
    .clock    (clock),
    .reset    (reset),
    .inEnable (inEnable),
    .in       (in),
    .overflow (overflow),
    .port     (readPort)
  );

  burstCounter u_counter (
    .clock     (clock),
    .reset     (reset),
    .load      (load),
    .loadValue (loadValue),
    .step      (step),
    .last      (last)
  );

  drainControl u_control (
    .clock       (clock),
    .reset       (reset),
    .flush       (flush),
    .port        (readPort),
    .load        (load),
    .loadValue   (loadValue),
    .step        (step),
    .last        (last),
    .burstActive (burstActive)
  );

  // Interface signals out to plain ports
  assign inRemainder  = readPort.inRemainder;
  assign outRemainder = readPort.outRemainder;
  assign out          = readPort.readData;
  assign outValid     = readPort.readValid;

endmodule

/* testbench/burstBufferTb.sv */
//------------------------------
// Burst buffer testbench
// Clock, reset, directed and random stimulus,
// byte queue reference model, comparing process, summary
//------------------------------
`timescale 1ns/1ps

module burstBufferTb import burstBufferPkg::*; ();

  //------------------------------
  // Limits
  //------------------------------
  localparam int StrobeTimeout = 40;                     // Cycles to first output byte
  localparam int DrainTimeout  = 200;                    // Cycles to empty the buffer
  localparam int FillLimit     = 500;                    // Writes allowed to reach full
  localparam int RandomCycles  = 400;                    // Length of random stream

  // DUT signals
  logic       clock;
  logic       reset;
  logic       inEnable;
  payloadType dataIn;
  logic       flush;
  countType   inRemainder;
  countType   outRemainder;
  payloadType out;
  logic       outValid;
  logic       overflow;
  logic       burstActive;

  // Reference model and bookkeeping
  payloadType modelQueue [$];                            // Stored bytes with the head first
  logic       sampledEnable;                             // Write seen by the last edge
  payloadType sampledData;
  int         strobeCount;                               // Bytes seen on out
  int         overflowCount;                             // Overflow pulses seen
  int         pushCount;                                 // Writes accepted by model
  int         errorCount;
  int         errorsAtStart;
  int         testsRun;
  int         testsFailed;
  bit         timedOut;
  string      testName;
  integer     seed;

  burstBuffer u_dut (
    .clock        (clock),
    .reset        (reset),
    .inEnable     (inEnable),
    .in           (dataIn),
    .flush        (flush),
    .inRemainder  (inRemainder),
    .outRemainder (outRemainder),
    .out          (out),
    .outValid     (outValid),
    .overflow     (overflow),
    .burstActive  (burstActive)
  );

  always #50 clock = ~clock;                             // 100 ns period

  //------------------------------
  // Reference and checks
  //------------------------------
  // Queue head is the next byte out and its size gives the remainders
  function automatic payloadType predictOutput(output countType expectIn,
                                               output countType expectOut);
    payloadType head;
    head      = (modelQueue.size() > 0) ? modelQueue[0] : '0;
    expectOut = countType'(modelQueue.size());
    expectIn  = countType'(BufferDepth) - expectOut;
    return head;
  endfunction

  task automatic compareValue(input string what, input int expected, input int actual);
    assert (expected == actual) else begin
      $display("FAILED %s (%s): expected %0h actual %0h", testName, what, expected, actual);
      errorCount++;
    end
  endtask

  // Outputs are stable at the falling edge
  always @(negedge clock) begin : compare
    payloadType expectByte;
    countType   expectIn;
    countType   expectOut;
    logic       wasFull;
    logic       expectOverflow;
    if (reset) begin
      modelQueue.delete();
      sampledEnable = 1'b0;                              // Nothing pending across reset
    end else begin
      wasFull        = (modelQueue.size() == BufferDepth); // Occupancy before the edge
      expectOverflow = sampledEnable && wasFull;
      if (outValid) begin
        assert (modelQueue.size() > 0) else begin
          $display("%s: output strobe while the reference queue is empty", testName);
          errorCount++;
        end
        expectByte = predictOutput(expectIn, expectOut);
        compareValue("output byte", int'(expectByte), int'(out));
        if (modelQueue.size() > 0) begin
          void'(modelQueue.pop_front());
        end
        strobeCount++;
      end
      if (sampledEnable && !wasFull) begin
        modelQueue.push_back(sampledData);               // Accepted write
        pushCount++;
      end
      void'(predictOutput(expectIn, expectOut));
      compareValue("outRemainder", int'(expectOut), int'(outRemainder));
      compareValue("inRemainder", int'(expectIn), int'(inRemainder));
      compareValue("remainder sum", BufferDepth, int'(inRemainder) + int'(outRemainder));
      compareValue("overflow", int'(expectOverflow), int'(overflow));
      if (overflow) begin
        overflowCount++;
      end
      sampledEnable = inEnable;                          // Taken at the next edge
      sampledData   = dataIn;
    end
  end

  //------------------------------
  // Stimulus helpers
  //------------------------------
  task automatic nextCycle();
    @(posedge clock);
    #1;                                                  // Drive after the edge
  endtask

  task automatic writeByte(input payloadType value);
    inEnable = 1'b1;
    dataIn   = value;
    nextCycle();
    inEnable = 1'b0;
  endtask

  task automatic waitForStrobe(input int limit);
    int cycles;
    cycles = 0;
    while (!outValid && cycles < limit) begin
      nextCycle();
      cycles++;
    end
    if (!outValid) begin
      $display("%s: timeout, no output byte within %0d cycles", testName, limit);
      timedOut = 1'b1;
    end
  endtask

  // Hold flush until the buffer is empty and the last byte has left
  task automatic drainBuffer(input int limit);
    int  cycles;
    logic done;
    cycles = 0;
    done   = 1'b0;
    flush  = 1'b1;
    while (!done && cycles < limit) begin
      nextCycle();
      cycles++;
      done = (outRemainder == '0) && !outValid;
    end
    flush = 1'b0;
    if (!done) begin
      $display("%s: timeout, buffer not empty after %0d cycles", testName, limit);
      timedOut = 1'b1;
    end
  endtask

  task automatic startTest(input string name);
    testName      = name;
    errorsAtStart = errorCount;
  endtask

  task automatic finishTest();
    testsRun++;
    if (errorCount != errorsAtStart || timedOut) begin
      testsFailed++;
    end
    $display("test %-12s done, %0d check(s) failed", testName, errorCount - errorsAtStart);
  endtask

  //------------------------------
  // Tests
  //------------------------------
  task automatic resetValues();
    startTest("reset");
    compareValue("outRemainder", 0, int'(outRemainder));
    compareValue("inRemainder", BufferDepth, int'(inRemainder));
    compareValue("outValid", 0, int'(outValid));
    compareValue("overflow", 0, int'(overflow));
    compareValue("burstActive", 0, int'(burstActive));
    finishTest();
  endtask

  task automatic partialFill();
    int strobesBefore;
    startTest("partial");
    strobesBefore = strobeCount;
    for (int k = 1; k < BurstLength; k++) begin
      writeByte(payloadType'(8'h10 + k));
      compareValue("stored count", k, int'(outRemainder));
    end
    repeat (4) nextCycle();                              // Nothing may leave
    compareValue("output bytes", 0, strobeCount - strobesBefore);
    finishTest();
  endtask

  task automatic fullBurst();
    int run;
    startTest("burst");
    writeByte(8'h5a);                                    // Completes a burst
    waitForStrobe(StrobeTimeout);
    if (!timedOut) begin
      compareValue("burstActive at first byte", 1, int'(burstActive));
      run = 0;
      while (outValid && run < 2 * BurstLength) begin
        run++;
        nextCycle();
      end
      compareValue("consecutive strobes", BurstLength, run);
      compareValue("stored after burst", 0, int'(outRemainder));
      compareValue("burstActive after burst", 0, int'(burstActive));
    end
    finishTest();
  endtask

  task automatic flushPartial();
    int strobesBefore;
    startTest("flush");
    writeByte(8'ha1);
    writeByte(8'ha2);
    strobesBefore = strobeCount;
    drainBuffer(DrainTimeout);
    compareValue("flushed bytes", 2, strobeCount - strobesBefore);
    compareValue("stored after flush", 0, int'(outRemainder));
    finishTest();
  endtask

  task automatic overflowDrop();
    int         writes;
    int         overflowBefore;
    payloadType fillValue;
    startTest("overflow");
    writes    = 0;
    fillValue = 8'h00;
    while (inRemainder != '0 && writes < FillLimit) begin
      writeByte(fillValue);
      fillValue++;
      writes++;
    end
    if (inRemainder != '0) begin
      $display("%s: timeout, buffer not full after %0d writes", testName, writes);
      timedOut = 1'b1;
    end else begin
      overflowBefore = overflowCount;
      writeByte(8'hff);                                  // Dropped since the buffer is full
      nextCycle();
      compareValue("overflow pulses", 1, overflowCount - overflowBefore);
      drainBuffer(DrainTimeout);
    end
    finishTest();
  endtask

  task automatic randomStream();
    logic [31:0] randomValue;
    int          pushesBefore;
    int          strobesBefore;
    startTest("random");
    pushesBefore  = pushCount;
    strobesBefore = strobeCount;
    for (int cycle = 0; cycle < RandomCycles; cycle++) begin
      randomValue = $random(seed);
      inEnable    = (randomValue[1:0] != 2'b00) && (inRemainder != '0); // Respect free space
      dataIn      = randomValue[15:8];
      flush       = (randomValue[19:16] == 4'd0);        // Occasional flush request
      nextCycle();
    end
    inEnable = 1'b0;
    flush    = 1'b0;
    drainBuffer(DrainTimeout);
    compareValue("bytes in versus out", pushCount - pushesBefore, strobeCount - strobesBefore);
    compareValue("model left over", 0, modelQueue.size());
    finishTest();
  endtask

  //------------------------------
  // Main sequence
  //------------------------------
  initial begin
    clock         = 1'b0;
    reset         = 1'b1;
    inEnable      = 1'b0;
    dataIn        = '0;
    flush         = 1'b0;
    sampledEnable = 1'b0;
    sampledData   = '0;
    strobeCount   = 0;
    overflowCount = 0;
    pushCount     = 0;
    errorCount    = 0;
    errorsAtStart = 0;
    testsRun      = 0;
    testsFailed   = 0;
    timedOut      = 1'b0;
    testName      = "setup";
    seed          = 32'h9f79_86aa;

    repeat (8) @(posedge clock);                         // Reset for 8 cycles
    #1;
    reset = 1'b0;
    nextCycle();

    resetValues();
    if (!timedOut) partialFill();
    if (!timedOut) fullBurst();
    if (!timedOut) flushPartial();
    if (!timedOut) overflowDrop();
    if (!timedOut) randomStream();

    $display("tests run %0d, tests failed %0d, checks failed %0d",
             testsRun, testsFailed, errorCount);
    if (errorCount == 0 && !timedOut) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

/* vlog.f */
src/burstBufferPkg.sv
src/bufferPort.sv
src/circularBuffer.sv
src/burstCounter.sv
src/drainControl.sv
src/burstBuffer.sv
testbench/burstBufferTb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the burst buffer testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --assert -f vlog.f --top-module burstBufferTb -o burstBufferSim \
  > sim.log 2>&1 \
  && ./obj_dir/burstBufferSim >> sim.log 2>&1

grep -q "^Testbench passed$" sim.log \
  && echo "PASS" \
  || { echo "FAIL, see sim.log"; exit 1; }
